/* hdl/basicOpIf.sv */
`default_nettype none

interface basicOpIf;
  import lsfLspPkg::*;

  basicOpT              op;
  logic [dataWidth-1:0] operandA;
  logic [wordWidth-1:0] operandB;
  logic [dataWidth-1:0] result;
  logic                 valid;

  modport client (output op, operandA, operandB, valid, input result);
  modport unit (input op, operandA, operandB, valid, output result);
endinterface

`default_nettype wire

/* hdl/basicOpUnit.sv */
`default_nettype none

module basicOpUnit (
  basicOpIf.unit opBus
);
  import lsfLspPkg::*;

  logic signed [wordWidth-1:0] a16;
  logic signed [wordWidth-1:0] b16;
  logic signed [dataWidth-1:0] product;

  function automatic logic signed [wordWidth-1:0] sat16(input logic signed [63:0] x);
    if (x > 64'sd32767)
      return 16'sh7fff;
    if (x < -64'sd32768)
      return 16'sh8000;
    return x[wordWidth-1:0];
  endfunction

  function automatic logic signed [dataWidth-1:0] sat32(input logic signed [63:0] x);
    if (x > 64'sh0000_0000_7fff_ffff)
      return 32'sh7fff_ffff;
    if (x < -64'sh0000_0000_8000_0000)
      return 32'sh8000_0000;
    return x[dataWidth-1:0];
  endfunction

  // Negative count shifts left and sat16/sat32 catch the overflow
  function automatic logic signed [63:0] shiftWide(input logic signed [63:0] x,
                                                   input logic signed [15:0] count);
    logic [15:0] mag;
    if (count < 0)
    begin
      mag = -count;
      if (mag > 16'd32)
        mag = 16'd32;
      return x <<< mag;
    end
    mag = count;
    if (mag > 16'd63)
      mag = 16'd63;
    return x >>> mag;
  endfunction

  always_comb
  begin
    a16     = opBus.operandA[wordWidth-1:0];
    b16     = opBus.operandB;
    product = a16 * b16;
    case (opBus.op)
      opMult:  opBus.result = signExtend(sat16(product >>> 15));
      opShr:   opBus.result = signExtend(sat16(shiftWide(a16, b16)));
      opSub:   opBus.result = signExtend(sat16(a16 - b16));
      opAdd:   opBus.result = signExtend(sat16(a16 + b16));
      // Only -1 * -1 overflows the doubled product
      opLMult: opBus.result = (product == 32'sh4000_0000) ? 32'sh7fff_ffff : product <<< 1;
      opLShr:  opBus.result = sat32(shiftWide($signed(opBus.operandA), b16));
      default: opBus.result = '0;
    endcase
  end

  // A result in use needs a decodable operator and known operands
  always_comb
  begin
    if (opBus.valid)
      assert final (!$isunknown({opBus.operandA, opBus.operandB})
                    && opBus.op inside {opMult, opShr, opSub, opAdd, opLMult, opLShr})
        else $error("basicOpUnit: bad request, operator code %0d", opBus.op);
  end
endmodule

`default_nettype wire

/* hdl/cosSlopeRom.sv */
`default_nettype none

module cosSlopeRom (
  input  logic                                 clk,
  input  logic [lsfLspPkg::tableAddrWidth-1:0] addr,
  output logic [lsfLspPkg::dataWidth-1:0]      data
);
  import lsfLspPkg::*;

  // Upper half cosine, lower half slope
  logic [dataWidth-1:0] romArray [0:tableDepth-1];

  initial
  begin
    $readmemh(tableFile, romArray);
  end

  always_ff @(posedge clk)
  begin
    data <= romArray[addr];
  end
endmodule

`default_nettype wire

/* hdl/cosSlopeTable.mem */
// Columns: table2 cosine (Q15, bits 31:16), slope_cos (bits 15:0), entries 0 to 64
7FFFFD88
7FD9F89B
7F62F3B2
7E9DEED1
7D8AE9FA
7C2AE531
7A7DE078
7885DBD3
7642D744
73B6D2CE
70E3CE74
6DCACA39
6A6EC61F
66D0C228
62F2BE58
5ED7BAB0
5A82B733
55F6B3E2
5134B0C1
4C40ADD1
471DAB13
41CEA88A
3C57A636
36BAA41A
30FCA237
2B1FA08D
25289F1F
1F1A9DEC
18F99CF6
12C89C3C
0C8C9BC0
06489B82
00009B82
F9B89BC0
F3749C3C
ED389CF6
E7079DEC
E0E69F1F
DAD8A08D
D4E1A237
CF04A41A
C946A636
C3A9A88A
BE32AB13
B8E3ADD1
B3C0B0C1
AECCB3E2
AA0AB733
A57EBAB0
A129BE58
9D0EC228
9930C61F
9592CA39
9236CE74
8F1DD2CE
8C4AD744
89BEDBD3
877BE078
8583E531
83D6E9FA
8276EED1
8163F3B2
809EF89B
8027FD88
80000000

/* hdl/lsfLspController.sv */
`default_nettype none

module lsfLspController (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 start,
  input  logic [lsfLspPkg::addrWidth-1:0]      lsfAddr,
  input  logic [lsfLspPkg::addrWidth-1:0]      lspAddr,
  input  logic [lsfLspPkg::dataWidth-1:0]      memIn,
  output logic [lsfLspPkg::addrWidth-1:0]      memReadAddr,
  output logic [lsfLspPkg::addrWidth-1:0]      memWriteAddr,
  output logic [lsfLspPkg::dataWidth-1:0]      memOut,
  output logic                                 memWriteEn,
  output logic [lsfLspPkg::tableAddrWidth-1:0] tableAddr,
  input  logic [lsfLspPkg::dataWidth-1:0]      tableData,
  output logic                                 done,
  basicOpIf.client                             opBus
);
  import lsfLspPkg::*;

  ctrlStateT                     state;
  logic [$clog2(lpcOrder)-1:0]   coefIndex;
  logic [addrWidth-1:0]          lsfBase;
  logic [addrWidth-1:0]          lspBase;
  logic [wordWidth-1:0]          freq;
  logic [wordWidth-1:0]          ind;
  logic [7:0]                    offset;
  logic [wordWidth-1:0]          cosVal;
  logic [dataWidth-1:0]          product;
  logic [wordWidth-1:0]          slopeTerm;

  assign memReadAddr = lsfBase + addrWidth'(coefIndex);

  //////////////////////////////////////////////////////////////////////
  // Operator requests, one per arithmetic state
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    opBus.op       = opMult;
    opBus.operandA = '0;
    opBus.operandB = '0;
    opBus.valid    = 1'b1;
    case (state)
      stScale:  begin opBus.op = opMult;  opBus.operandA = signExtend(memIn[wordWidth-1:0]);
                      opBus.operandB = wordWidth'(freqScale); end
      stIndex:  begin opBus.op = opShr;   opBus.operandA = signExtend(freq);
                      opBus.operandB = wordWidth'(8); end
      stClamp:  begin opBus.op = opSub;   opBus.operandA = signExtend(ind);
                      opBus.operandB = wordWidth'(indexLimit); end
      stInterp: begin opBus.op = opLMult; opBus.operandA = signExtend(tableData[wordWidth-1:0]);
                      opBus.operandB = {8'd0, offset}; end
      stShift:  begin opBus.op = opLShr;  opBus.operandA = product;
                      opBus.operandB = wordWidth'(slopeShift); end
      stSum:    begin opBus.op = opAdd;   opBus.operandA = signExtend(cosVal);
                      opBus.operandB = slopeTerm; end
      default:  opBus.valid = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= stIdle;
      coefIndex  <= '0;
      tableAddr  <= '0;
      memWriteEn <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        stIdle:   if (start) begin coefIndex <= '0; state <= stFetch; end
        stFetch:  state <= stScale;
        stScale:  state <= stIndex;
        stIndex:  state <= stClamp;
        stClamp:
        begin
          // Positive difference means ind ran past the table end
          if ($signed(opBus.result[wordWidth-1:0]) > 0)
            tableAddr <= tableAddrWidth'(indexLimit);
          else
            tableAddr <= ind[tableAddrWidth-1:0];
          state <= stLookup;
        end
        stLookup: state <= stInterp;
        stInterp: state <= stShift;
        stShift:  state <= stSum;
        stSum:    begin memWriteEn <= 1'b1; state <= stStore; end
        stStore:
        begin
          memWriteEn <= 1'b0;
          if (coefIndex == lpcOrder - 1)
          begin
            done  <= 1'b1;
            state <= stIdle;
          end
          else
          begin
            coefIndex <= coefIndex + 1'b1;
            state     <= stFetch;
          end
        end
        default:  state <= stIdle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk)
  begin
    case (state)
      stIdle:   if (start) begin lsfBase <= lsfAddr; lspBase <= lspAddr; end
      stScale:  freq <= opBus.result[wordWidth-1:0];
      stIndex:  begin ind <= opBus.result[wordWidth-1:0]; offset <= freq[7:0]; end
      stInterp: begin product <= opBus.result; cosVal <= tableData[dataWidth-1:wordWidth]; end
      stShift:  slopeTerm <= opBus.result[wordWidth-1:0];
      stSum:    begin memOut <= opBus.result; memWriteAddr <= lspBase + addrWidth'(coefIndex); end
      default:  ;
    endcase
  end

  noWriteWhenIdle: assert property (@(posedge clk) disable iff (reset)
    state == stIdle |-> !memWriteEn) else $error("lsfLspController: write while idle");
  tableInRange: assert property (@(posedge clk) disable iff (reset)
    tableAddr <= indexLimit) else $error("lsfLspController: table index %0d", tableAddr);
endmodule

`default_nettype wire

/* hdl/lsfLspPipe.sv */
`default_nettype none

module lsfLspPipe (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic [lsfLspPkg::addrWidth-1:0] lsfAddr,
  input  logic [lsfLspPkg::addrWidth-1:0] lspAddr,
  input  logic [lsfLspPkg::addrWidth-1:0] testReadAddr,
  input  logic [lsfLspPkg::addrWidth-1:0] testWriteAddr,
  input  logic [lsfLspPkg::dataWidth-1:0] testMemOut,
  input  logic                            testWriteEn,
  input  logic                            memMuxSel,
  output logic                            done,
  output logic [lsfLspPkg::dataWidth-1:0] memIn
);
  import lsfLspPkg::*;

  logic [addrWidth-1:0]      ctrlReadAddr,  ctrlWriteAddr;
  logic [dataWidth-1:0]      ctrlWriteData;
  logic                      ctrlWriteEn;
  logic [addrWidth-1:0]      ramReadAddr,   ramWriteAddr;
  logic [dataWidth-1:0]      ramWriteData;
  logic                      ramWriteEn;
  logic [tableAddrWidth-1:0] tableAddr;
  logic [dataWidth-1:0]      tableData;

  basicOpIf opBus ();

  lsfLspController u_controller (
    .clk(clk), .reset(reset), .start(start),
    .lsfAddr(lsfAddr), .lspAddr(lspAddr), .memIn(memIn),
    .memReadAddr(ctrlReadAddr), .memWriteAddr(ctrlWriteAddr),
    .memOut(ctrlWriteData), .memWriteEn(ctrlWriteEn),
    .tableAddr(tableAddr), .tableData(tableData),
    .done(done), .opBus(opBus)
  );

  basicOpUnit u_opUnit (.opBus(opBus));

  cosSlopeRom u_cosSlopeRom (.clk(clk), .addr(tableAddr), .data(tableData));

  scratchMemory u_scratchMemory (
    .clk(clk), .writeAddr(ramWriteAddr), .writeData(ramWriteData),
    .writeEn(ramWriteEn), .readAddr(ramReadAddr), .readData(memIn)
  );

  //////////////////////////////////////////////////////////////////////
  // Test port muxes, low hands the memory to the outside
  //////////////////////////////////////////////////////////////////////
  assign ramReadAddr  = memMuxSel ? ctrlReadAddr  : testReadAddr;
  assign ramWriteAddr = memMuxSel ? ctrlWriteAddr : testWriteAddr;
  assign ramWriteData = memMuxSel ? ctrlWriteData : testMemOut;
  assign ramWriteEn   = memMuxSel ? ctrlWriteEn   : testWriteEn;
endmodule

`default_nettype wire

/* hdl/lsfLspPkg.sv */
`default_nettype none

package lsfLspPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and storage
  //////////////////////////////////////////////////////////////////////
  localparam int addrWidth      = 12;
  localparam int dataWidth      = 32;
  localparam int wordWidth      = 16;
  localparam int tableAddrWidth = 7;
  localparam int tableDepth     = 65;
  localparam string tableFile   = "hdl/cosSlopeTable.mem";

  //////////////////////////////////////////////////////////////////////
  // G.729 Lsf_lsp2 constants
  //////////////////////////////////////////////////////////////////////
  localparam int lpcOrder   = 10;
  // 0.6366 in Q15, maps 0..pi onto 0..64 table steps
  localparam int freqScale  = 20861;
  localparam int indexLimit = 63;
  localparam int slopeShift = 13;

  typedef enum logic [2:0] {
    opMult, opShr, opSub, opAdd, opLMult, opLShr
  } basicOpT;

  typedef enum logic [3:0] {
    stIdle, stFetch, stScale, stIndex, stClamp,
    stLookup, stInterp, stShift, stSum, stStore
  } ctrlStateT;

  // Widen a Q15 word onto the 32-bit operator and memory paths
  function automatic logic [dataWidth-1:0] signExtend(input logic [wordWidth-1:0] w);
    return {{(dataWidth - wordWidth){w[wordWidth-1]}}, w};
  endfunction

endpackage

`default_nettype wire

/* hdl/scratchMemory.sv */
`default_nettype none

module scratchMemory (
  input  logic                           clk,
  input  logic [lsfLspPkg::addrWidth-1:0] writeAddr,
  input  logic [lsfLspPkg::dataWidth-1:0] writeData,
  input  logic                           writeEn,
  input  logic [lsfLspPkg::addrWidth-1:0] readAddr,
  output logic [lsfLspPkg::dataWidth-1:0] readData
);
  import lsfLspPkg::*;

  logic [dataWidth-1:0] ram [0:(1 << addrWidth)-1];

  // Same-address read returns the old word
  always_ff @(posedge clk)
  begin
    if (writeEn)
      ram[writeAddr] <= writeData;
    readData <= ram[readAddr];
  end

  // Either the test port or the controller, whichever the mux selects
  writeAddrKnown: assert property (@(posedge clk) writeEn |-> !$isunknown(writeAddr))
    else $error("scratchMemory: write with unknown address");
endmodule

`default_nettype wire

/* list.f */
hdl/lsfLspPkg.sv
hdl/basicOpIf.sv
hdl/basicOpUnit.sv
hdl/cosSlopeRom.sv
hdl/scratchMemory.sv
hdl/lsfLspController.sv
hdl/lsfLspPipe.sv
verif/lsfLspTb.sv

/* verif/lsfLspTb.sv */
`default_nettype none

module lsfLspTb;
  timeunit 1ns;
  timeprecision 100ps;
  import lsfLspPkg::*;

  localparam int maxLatency = 100;
  // Five runs of up to 100 cycles, loads, reads and one 100-cycle idle watch
  localparam int cycleLimit = 2000;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 start;
  logic [addrWidth-1:0] lsfAddr;
  logic [addrWidth-1:0] lspAddr;
  logic [addrWidth-1:0] testReadAddr;
  logic [addrWidth-1:0] testWriteAddr;
  logic [dataWidth-1:0] testMemOut;
  logic                 testWriteEn;
  logic                 memMuxSel;
  logic                 done;
  logic [dataWidth-1:0] memIn;

  logic [wordWidth-1:0] lsfBuf [lpcOrder];
  logic [dataWidth-1:0] refTable [0:tableDepth-1];
  int                   cycleCount = 0;

  lsfLspPipe u_lsfLspPipe (
    .clk(clk), .reset(reset), .start(start),
    .lsfAddr(lsfAddr), .lspAddr(lspAddr),
    .testReadAddr(testReadAddr), .testWriteAddr(testWriteAddr),
    .testMemOut(testMemOut), .testWriteEn(testWriteEn),
    .memMuxSel(memMuxSel), .done(done), .memIn(memIn)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
      abortRun("Timeout: the run went past its cycle limit");
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  //////////////////////////////////////////////////////////////////////
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                           input logic [dataWidth-1:0] exp);
    if (got !== exp)
      abortRun($sformatf("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp));
  endtask

  task automatic checkLsp(input string name, input logic [wordWidth-1:0] got,
                          input logic [wordWidth-1:0] exp);
    if (got !== exp)
      abortRun($sformatf("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp));
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abortRun($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model of the G.729 Lsf_lsp2 step
  //////////////////////////////////////////////////////////////////////
  function automatic int toInt16(input logic [15:0] w);
    return int'($signed(w));
  endfunction

  function automatic int clip16(input longint x);
    if (x > 32767)
      return 32767;
    if (x < -32768)
      return -32768;
    return int'(x);
  endfunction

  function automatic logic [15:0] lspFromLsf(input logic [15:0] lsf);
    int          freq;
    int          ind;
    int          offset;
    longint      prod;
    logic [63:0] shifted;
    begin
      freq = clip16((longint'(toInt16(lsf)) * freqScale) >>> 15);
      ind = freq >>> 8;
      offset = freq & 255;
      if (clip16(ind - indexLimit) > 0)
        ind = indexLimit;
      // Doubled L_mult product cannot saturate with an 8-bit offset
      prod = 2 * longint'(toInt16(refTable[ind][15:0])) * offset;
      shifted = prod >>> slopeShift;
      return 16'(clip16(toInt16(refTable[ind][31:16]) + toInt16(shifted[15:0])));
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus helpers
  //////////////////////////////////////////////////////////////////////
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [dataWidth-1:0] fillPattern(input logic [addrWidth-1:0] addr);
    return {addr, ~addr, addr[7:0]};
  endfunction

  task automatic writeWord(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
    testWriteAddr = addr;
    testMemOut    = data;
    testWriteEn   = 1'b1;
    tick();
    testWriteEn   = 1'b0;
  endtask

  task automatic readWord(input logic [addrWidth-1:0] addr, output logic [dataWidth-1:0] data);
    testReadAddr = addr;
    tick();
    data = memIn;
  endtask

  // Load lsfBuf, run one conversion, then check outputs, inputs and guards
  task automatic runAndCheck(input logic [addrWidth-1:0] lsfBase,
                             input logic [addrWidth-1:0] lspBase, input bit extraStart);
    logic [dataWidth-1:0] inWords [lpcOrder];
    logic [dataWidth-1:0] word;
    logic [wordWidth-1:0] expLsp;
    logic [addrWidth-1:0] lowGuard;
    logic [addrWidth-1:0] highGuard;
    int                   n;
    begin
      lowGuard  = lspBase - 1'b1;
      highGuard = lspBase + addrWidth'(lpcOrder);
      memMuxSel = 1'b0;
      for (int i = 0; i < lpcOrder; i++)
      begin
        // Upper half is noise the controller must ignore
        inWords[i] = {16'($urandom), lsfBuf[i]};
        writeWord(lsfBase + addrWidth'(i), inWords[i]);
      end
      writeWord(lowGuard, fillPattern(lowGuard));
      writeWord(highGuard, fillPattern(highGuard));

      lsfAddr   = lsfBase;
      lspAddr   = lspBase;
      memMuxSel = 1'b1;
      start     = 1'b1;
      tick();
      start = 1'b0;
      n = 0;
      while (!done && n < maxLatency)
      begin
        start = extraStart && (n == 4);
        tick();
        n++;
      end
      start = 1'b0;
      if (!done)
        abortRun("Conversion gave no done pulse within 100 cycles of start");
      tick();
      checkBit("done", done, 1'b0);
      if (extraStart)
        repeat (maxLatency)
        begin
          tick();
          checkBit("done", done, 1'b0);
        end

      memMuxSel = 1'b0;
      for (int i = 0; i < lpcOrder; i++)
      begin
        readWord(lspBase + addrWidth'(i), word);
        expLsp = lspFromLsf(lsfBuf[i]);
        checkLsp($sformatf("lsp[%0d]", i), word[wordWidth-1:0], expLsp);
        checkWord($sformatf("lsp word %0d", i), word, {{16{expLsp[15]}}, expLsp});
      end
      for (int i = 0; i < lpcOrder; i++)
      begin
        readWord(lsfBase + addrWidth'(i), word);
        checkWord($sformatf("lsf word %0d", i), word, inWords[i]);
      end
      readWord(lowGuard, word);
      checkWord("guard below lsp block", word, fillPattern(lowGuard));
      readWord(highGuard, word);
      checkWord("guard above lsp block", word, fillPattern(highGuard));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic resetAndMemoryRoundTrip();
    logic [addrWidth-1:0] addrs [6];
    logic [dataWidth-1:0] word;
    begin
      addrs = '{12'h000, 12'h001, 12'h2a5, 12'h7ff, 12'h800, 12'hfff};
      checkBit("done", done, 1'b0);
      memMuxSel = 1'b0;
      foreach (addrs[i])
        writeWord(addrs[i], fillPattern(addrs[i]));
      foreach (addrs[i])
      begin
        readWord(addrs[i], word);
        checkWord("memIn", word, fillPattern(addrs[i]));
      end
    end
  endtask

  task automatic directedConversion();
    // Ascending Q2.13 values from 0 up to just under pi
    lsfBuf = '{16'd0, 16'd2000, 16'd4500, 16'd7000, 16'd9800,
               16'd12345, 16'd15000, 16'd18500, 16'd22000, 16'd25735};
    runAndCheck(12'd16, 12'd64, 1'b0);
  endtask

  task automatic randomConversion();
    foreach (lsfBuf[i])
      lsfBuf[i] = 16'($urandom_range(32767, 0));
    // One value past pi so the index clamp is always hit
    lsfBuf[$urandom_range(lpcOrder - 1, 0)] = 16'($urandom_range(32767, 25800));
    runAndCheck(12'd512, 12'd600, 1'b0);
  endtask

  task automatic backToBackRuns();
    foreach (lsfBuf[i])
      lsfBuf[i] = 16'($urandom_range(32767, 0));
    runAndCheck(12'd1000, 12'd1100, 1'b0);
    foreach (lsfBuf[i])
      lsfBuf[i] = 16'($urandom_range(32767, 0));
    runAndCheck(12'd2000, 12'd2100, 1'b0);
  endtask

  task automatic startDuringRun();
    foreach (lsfBuf[i])
      lsfBuf[i] = 16'($urandom_range(32767, 0));
    runAndCheck(12'd3000, 12'd3100, 1'b1);
  endtask

  initial
  begin
    void'($urandom(32'hbc25a1d8));
    $readmemh(tableFile, refTable);
    reset         = 1'b1;
    start         = 1'b0;
    lsfAddr       = '0;
    lspAddr       = '0;
    testReadAddr  = '0;
    testWriteAddr = '0;
    testMemOut    = '0;
    testWriteEn   = 1'b0;
    memMuxSel     = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    resetAndMemoryRoundTrip();
    directedConversion();
    randomConversion();
    backToBackRuns();
    startDuringRun();

    $display("ALL TESTS PASSED");
    $finish;
  end
endmodule

`default_nettype wire
